/* common/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int PC_W       = 40;
    localparam int BUS_ADDR_W = 39;     // sv39 sized physical address

    typedef logic [31:0] instr_t;

    localparam logic [PC_W-1:0] RESET_PC = 40'h00_8000_0000;  // ram base
    localparam instr_t          NOP_INSN = 32'h0000_0013;     // addi x0, x0, 0

    // major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_W     = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam logic [11:0] FUNCT12_MRET = 12'h302;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam logic [XLEN-1:0] IRQ_CAUSE = 64'h8000_0000_0000_000B;  // msb set, code 11

    typedef enum logic [3:0] {
        CLS_NONE, CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JAL,
        CLS_JALR, CLS_LUI, CLS_AUIPC, CLS_CSRRW, CLS_MRET
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef struct packed {
        op_class_e       cls;
        alu_op_e         alu_op;
        logic            word;      // 32-bit word form
        logic            use_imm;   // b operand is the immediate
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic [XLEN-1:0] imm;
        logic [11:0]     csr;
    } dec_t;

    typedef struct packed {
        logic                  valid;
        logic                  store;
        logic [2:0]            ls_type;   // funct3 of the access
        logic [BUS_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [BUS_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
        logic                  we;
        logic                  re;
        logic [2:0]            ls_type;
    } bus_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            read_done;
        logic            write_done;
    } bus_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
    } csr_wr_t;

endpackage

/* hdl/rv_decoder.sv */
`timescale 1ns/1ns
module rv_decoder
    import rv_core_pkg::*;
(
    input  instr_t ir_i,
    output dec_t   dec_o
);

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      f3;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    alu_op_e         arith_op;

    assign opcode = ir_i[6:0];
    assign funct7 = ir_i[31:25];
    assign f3     = ir_i[14:12];

    // sign extended immediates
    assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
    assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_j = {{43{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    assign imm_b = {{51{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

    // same funct3 map for imm and reg forms
    always_comb begin
        case (f3)
            3'b000:  arith_op = (opcode[5] && funct7[5]) ? ALU_SUB : ALU_ADD;  // sub reg form only
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;  // bit 30
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_o        = '0;          // unknown words retire as no-ops
        dec_o.alu_op = ALU_ADD;     // address and jalr target by default
        dec_o.rd     = ir_i[11:7];
        dec_o.rs1    = ir_i[19:15];
        dec_o.rs2    = ir_i[24:20];
        dec_o.funct3 = f3;
        dec_o.csr    = ir_i[31:20];
        dec_o.imm    = imm_i;
        case (opcode)
            OPC_LUI: begin
                dec_o.cls = CLS_LUI;
                dec_o.imm = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.cls     = CLS_AUIPC;
                dec_o.imm     = imm_u;
                dec_o.use_imm = 1'b1;
            end
            OPC_JAL: begin
                dec_o.cls = CLS_JAL;
                dec_o.imm = imm_j;
            end
            OPC_BRANCH: begin
                dec_o.cls = CLS_BRANCH;
                dec_o.imm = imm_b;
            end
            OPC_JALR: begin
                dec_o.cls     = CLS_JALR;
                dec_o.use_imm = 1'b1;
            end
            OPC_LOAD: begin
                dec_o.cls     = CLS_LOAD;
                dec_o.use_imm = 1'b1;
            end
            OPC_STORE: begin
                dec_o.cls     = CLS_STORE;
                dec_o.imm     = imm_s;
                dec_o.use_imm = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM_W, OPC_OP, OPC_OP_W: begin
                dec_o.alu_op  = arith_op;
                dec_o.use_imm = !opcode[5];     // reg forms have bit 5 set
                dec_o.word    = opcode[3];
                // word forms exist only for add/sub and shifts
                if (!opcode[3] || f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101) begin
                    dec_o.cls = CLS_ALU;
                end
            end
            OPC_SYSTEM: begin
                if (f3 == 3'b000 && ir_i[31:20] == FUNCT12_MRET) begin
                    dec_o.cls = CLS_MRET;
                end else if (f3 == 3'b001) begin
                    dec_o.cls = CLS_CSRRW;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ns
module rv_alu
    import rv_core_pkg::*;
(
    input  alu_op_e         op_i,
    input  logic            word_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  logic [2:0]      funct3_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o
);

    logic [5:0]             shamt;
    logic [XLEN-1:0]        res;
    logic signed [XLEN-1:0] sra_d;
    logic signed [31:0]     sra_w;

    assign shamt = word_i ? {1'b0, b_i[4:0]} : b_i[5:0];   // 5 bits in word mode
    assign sra_d = $signed(a_i) >>> shamt;
    assign sra_w = $signed(a_i[31:0]) >>> shamt[4:0];

    always_comb begin
        case (op_i)
            ALU_SUB:  res = a_i - b_i;
            ALU_XOR:  res = a_i ^ b_i;
            ALU_OR:   res = a_i | b_i;
            ALU_AND:  res = a_i & b_i;
            ALU_SLL:  res = a_i << shamt;
            ALU_SRL:  res = word_i ? ({32'b0, a_i[31:0]} >> shamt) : (a_i >> shamt);
            ALU_SRA:  res = word_i ? {32'b0, sra_w} : sra_d;
            ALU_SLT:  res = {63'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: res = {63'b0, a_i < b_i};
            default:  res = a_i + b_i;
        endcase
    end

    // word results take bit 31 as sign
    assign result_o = word_i ? {{32{res[31]}}, res[31:0]} : res;

    always_comb begin
        case (funct3_i)
            3'b000:  branch_taken_o = a_i == b_i;                     // beq
            3'b001:  branch_taken_o = a_i != b_i;                     // bne
            3'b100:  branch_taken_o = $signed(a_i) < $signed(b_i);    // blt
            3'b101:  branch_taken_o = $signed(a_i) >= $signed(b_i);   // bge
            3'b110:  branch_taken_o = a_i < b_i;                      // bltu
            3'b111:  branch_taken_o = a_i >= b_i;                     // bgeu
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ns
module rv_regfile
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            we_i,
    input  logic [4:0]      rd_addr_i,
    input  logic [XLEN-1:0] rd_data_i
);

    logic [XLEN-1:0] regs [0:31];   // x0 never written

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we_i && rd_addr_i != 5'd0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

/* bus_unit/rv_bus_unit.sv */
`timescale 1ns/1ns
module rv_bus_unit
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  mem_req_t        req_i,
    output logic            done_o,
    output logic [XLEN-1:0] load_data_o,
    output bus_req_t        bus_req_o,
    input  bus_rsp_t        bus_rsp_i
);

    bus_req_t        req_q;     // held stable until done
    logic            busy;
    logic [XLEN-1:0] wdata_m;
    logic [XLEN-1:0] rdata;

    assign busy      = req_q.we | req_q.re;
    assign done_o    = (req_q.we & bus_rsp_i.write_done) | (req_q.re & bus_rsp_i.read_done);
    assign bus_req_o = req_q;
    assign rdata     = bus_rsp_i.rdata;

    // stores carry only the bytes of their width
    always_comb begin
        case (req_i.ls_type[1:0])
            2'b00:   wdata_m = {56'b0, req_i.wdata[7:0]};     // sb
            2'b01:   wdata_m = {48'b0, req_i.wdata[15:0]};    // sh
            2'b10:   wdata_m = {32'b0, req_i.wdata[31:0]};    // sw
            default: wdata_m = req_i.wdata;                   // sd
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            req_q <= '0;
        end else if (!busy && req_i.valid) begin
            req_q.addr    <= req_i.addr;
            req_q.wdata   <= wdata_m;
            req_q.ls_type <= req_i.ls_type;
            req_q.we      <= req_i.store;
            req_q.re      <= !req_i.store;
        end else if (done_o) begin
            req_q.we <= 1'b0;       // enable drops the cycle after done
            req_q.re <= 1'b0;
        end
    end

    // read data comes right aligned
    always_comb begin
        case (req_q.ls_type)
            3'b000:  load_data_o = {{56{rdata[7]}}, rdata[7:0]};     // lb
            3'b001:  load_data_o = {{48{rdata[15]}}, rdata[15:0]};   // lh
            3'b010:  load_data_o = {{32{rdata[31]}}, rdata[31:0]};   // lw
            3'b100:  load_data_o = {56'b0, rdata[7:0]};              // lbu
            3'b101:  load_data_o = {48'b0, rdata[15:0]};             // lhu
            3'b110:  load_data_o = {32'b0, rdata[31:0]};             // lwu
            default: load_data_o = rdata;                            // ld
        endcase
    end

endmodule

/* csr_unit/rv_csr_file.sv */
`timescale 1ns/1ns
module rv_csr_file
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  csr_wr_t         wr_i,
    input  logic [11:0]     rd_addr_i,
    output logic [XLEN-1:0] rd_data_o,
    input  logic            trap_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic            mret_i,
    output logic            mie_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus              <= '0;
            mstatus[MSTATUS_MIE] <= 1'b1;   // interrupts on out of reset
            mtvec                <= '0;
        end else if (trap_i) begin
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0;
        end else if (mret_i) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
        end else if (wr_i.valid) begin
            if (wr_i.addr == CSR_MSTATUS) mstatus <= wr_i.data;
            if (wr_i.addr == CSR_MTVEC) mtvec <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_i) begin
            mepc   <= epc_i;        // insn that did not run
            mcause <= IRQ_CAUSE;
        end else if (wr_i.valid) begin
            case (wr_i.addr)
                CSR_MSCRATCH: mscratch <= wr_i.data;
                CSR_MEPC:     mepc     <= wr_i.data;
                CSR_MCAUSE:   mcause   <= wr_i.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (rd_addr_i)
            CSR_MSTATUS:  rd_data_o = mstatus;
            CSR_MTVEC:    rd_data_o = mtvec;
            CSR_MSCRATCH: rd_data_o = mscratch;
            CSR_MEPC:     rd_data_o = mepc;
            CSR_MCAUSE:   rd_data_o = mcause;
            default:      rd_data_o = '0;   // unknown csr reads zero
        endcase
    end

    assign mie_o   = mstatus[MSTATUS_MIE];
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/1ns
module rv_core_top
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  instr_t          instruction_i,
    output logic [PC_W-1:0] pc_o,
    input  logic            irq_i,
    output logic            irq_ack_o,
    output bus_req_t        bus_req_o,
    input  bus_rsp_t        bus_rsp_i
);

    instr_t          ir;            // fetch register
    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] ex_pc;
    logic [PC_W-1:0] pc_rel;
    logic [PC_W-1:0] next_pc;
    logic            bubble;
    logic            mem_wait;      // access issued, done not seen yet
    logic            ex_valid;
    logic            ex_mem;
    logic            take_irq;
    logic            redirect;
    logic            hold;
    logic            taken;
    logic            mem_done;
    logic            mie;
    logic            rf_we;
    dec_t            dec;
    mem_req_t        mem_req;
    csr_wr_t         csr_wr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    assign pc_o     = pc;
    assign ex_pc    = pc - PC_W'(4);    // address of the word in ir
    assign pc_rel   = ex_pc + dec.imm[PC_W-1:0];
    assign ex_valid = !bubble;
    assign ex_mem   = ex_valid && (dec.cls == CLS_LOAD || dec.cls == CLS_STORE);
    assign take_irq = ex_valid && !mem_wait && irq_i && mie;  // insn in ex does not run
    assign hold     = ex_mem && !mem_done;
    assign alu_a    = (dec.cls == CLS_AUIPC) ? XLEN'(ex_pc) : rs1_data;
    assign alu_b    = dec.use_imm ? dec.imm : rs2_data;

    rv_decoder u_dec (.ir_i(ir), .dec_o(dec));

    rv_regfile u_rf (
        .clk(clk), .reset(reset),
        .rs1_addr_i(dec.rs1), .rs2_addr_i(dec.rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .rd_addr_i(dec.rd), .rd_data_i(wb_data)
    );

    rv_alu u_alu (
        .op_i(dec.alu_op), .word_i(dec.word), .a_i(alu_a), .b_i(alu_b),
        .funct3_i(dec.funct3), .result_o(alu_res), .branch_taken_o(taken)
    );

    always_comb begin
        mem_req.valid   = ex_mem && !mem_wait && !take_irq;   // one issue per access
        mem_req.store   = dec.cls == CLS_STORE;
        mem_req.ls_type = dec.funct3;
        mem_req.addr    = alu_res[BUS_ADDR_W-1:0];
        mem_req.wdata   = rs2_data;
        csr_wr.valid    = ex_valid && !take_irq && dec.cls == CLS_CSRRW;
        csr_wr.addr     = dec.csr;
        csr_wr.data     = rs1_data;
    end

    rv_bus_unit u_bus (
        .clk(clk), .reset(reset), .req_i(mem_req), .done_o(mem_done),
        .load_data_o(load_data), .bus_req_o(bus_req_o), .bus_rsp_i(bus_rsp_i)
    );

    rv_csr_file u_csr (
        .clk(clk), .reset(reset), .wr_i(csr_wr), .rd_addr_i(dec.csr), .rd_data_o(csr_rdata),
        .trap_i(take_irq), .epc_i(XLEN'(ex_pc)),
        .mret_i(ex_valid && !take_irq && dec.cls == CLS_MRET),
        .mie_o(mie), .mtvec_o(mtvec), .mepc_o(mepc)
    );

    // write-back select, load lands in its done cycle
    assign rf_we = ex_valid && !take_irq
                && ((dec.cls inside {CLS_ALU, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_CSRRW})
                    || (dec.cls == CLS_LOAD && mem_done));
    always_comb begin
        case (dec.cls)
            CLS_LOAD:          wb_data = load_data;
            CLS_JAL, CLS_JALR: wb_data = XLEN'(ex_pc + PC_W'(4));  // link
            CLS_LUI:           wb_data = dec.imm;
            CLS_CSRRW:         wb_data = csr_rdata;     // old csr value
            default:           wb_data = alu_res;
        endcase
    end

    // next pc, every redirect costs one bubble
    always_comb begin
        redirect = 1'b1;
        if (take_irq) next_pc = mtvec[PC_W-1:0];
        else if (ex_valid && dec.cls == CLS_MRET) next_pc = mepc[PC_W-1:0];
        else if (ex_valid && (dec.cls == CLS_JAL || (dec.cls == CLS_BRANCH && taken))) begin
            next_pc = pc_rel;
        end else if (ex_valid && dec.cls == CLS_JALR) begin
            next_pc = {alu_res[PC_W-1:1], 1'b0};
        end else begin
            redirect = 1'b0;
            next_pc  = pc + PC_W'(4);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= RESET_PC;
            ir        <= NOP_INSN;
            bubble    <= 1'b1;      // nothing valid in ex yet
            mem_wait  <= 1'b0;
            irq_ack_o <= 1'b0;
        end else begin
            irq_ack_o <= take_irq;  // one pulse, mie drops on entry
            if (mem_req.valid) mem_wait <= 1'b1;
            else if (mem_done) mem_wait <= 1'b0;
            if (redirect) begin
                pc     <= next_pc;
                ir     <= NOP_INSN;  // drop the word already fetched
                bubble <= 1'b1;
            end else if (!hold) begin
                pc     <= next_pc;
                ir     <= instruction_i;
                bubble <= 1'b0;
            end
        end
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns
module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b0;                 // active low, held 3 cycles
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b1;
    end

    always #2 clk_o = ~clk_o;           // 4 ns period

endmodule

/* dv/tb_rv_core.sv */
`timescale 1ns/1ns
module tb_rv_core
    import rv_core_pkg::*;
;

    localparam int DATA_AT     = 'h80;  // initial data words for byte 0x100 up
    localparam int INFO_AT     = 'h88;  // record count and handler pc
    localparam int REC_AT      = 'h90;  // store records of three words each
    localparam int RUN_TIMEOUT = 3000;

    logic            clk;
    logic            reset;
    instr_t          instruction;
    logic [PC_W-1:0] pc;
    logic            irq;
    logic            irq_ack;
    bus_req_t        bus_req;
    bus_rsp_t        bus_rsp;

    logic [63:0]     pat [0:255];
    logic [7:0]      dmem [0:511];      // bytes 0x2000 to 0x21ff
    logic [31:0]     lfsr = 32'h9568c560;
    logic [PC_W-1:0] epc;
    logic [PC_W-1:0] handler_pc;
    bus_req_t        held;              // request as first seen
    logic            pending;
    logic            done_q;
    logic [1:0]      delay;
    int              rec_idx;
    int              rec_cnt;
    int              ack_cnt;
    int              errors;
    int              err_mark;
    int              tests_run;
    int              tests_failed;
    int              cycles;
    logic            timed_out;

    tb_clock_gen u_clk (.clk_o(clk), .reset_o(reset));

    rv_core_top UUT (
        .clk(clk), .reset(reset), .instruction_i(instruction), .pc_o(pc),
        .irq_i(irq), .irq_ack_o(irq_ack), .bus_req_o(bus_req), .bus_rsp_i(bus_rsp)
    );

    task automatic check_bus(input bus_req_t exp, input bus_req_t got, input string what);
        if (exp !== got) begin
            errors++;
            $display("Error at %0t ns: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_pc(input logic [PC_W-1:0] exp, input logic [PC_W-1:0] got,
                            input string what);
        if (exp !== got) begin
            errors++;
            $display("Error at %0t ns: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [1:0] take_bits();
        logic [1:0] v;
        v = '0;
        for (int i = 0; i < 2; i++) begin
            v    = {v[0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic string test_name(input logic [3:0] t);
        case (t)
            4'd1:    return "reset";
            4'd2:    return "arithmetic";
            4'd3:    return "control flow";
            4'd4:    return "loads and stores";
            default: return "interrupt";
        endcase
    endfunction

    task automatic report_test(input logic [3:0] t);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", t, test_name(t));
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", t, test_name(t), errors - err_mark);
        end
        err_mark = errors;
    endtask

    // next expected store against the one on the bus
    task automatic match_store();
        int          r;
        logic [63:0] ctl;
        bus_req_t    exp;
        r = REC_AT + 3 * rec_idx;
        if (rec_idx >= rec_cnt) begin
            errors++;
            $display("store to %h after the last expected store", held.addr);
            return;
        end
        ctl         = pat[r + 1];
        exp.addr    = pat[r][BUS_ADDR_W-1:0];
        exp.wdata   = (ctl[7:4] == 4'd1) ? {24'b0, epc} : pat[r + 2];  // mepc record
        exp.we      = 1'b1;
        exp.re      = 1'b0;
        exp.ls_type = ctl[2:0];
        check_bus(exp, held, "store on bus_req_o");
        if (ctl[7:4] == 4'd1) begin
            if (ack_cnt != 1) begin
                errors++;
                $display("handler store seen without exactly one irq_ack_o pulse");
            end
            if ((pc - 40'd4) < handler_pc || (pc - 40'd4) >= handler_pc + 40'h20) begin
                errors++;
                $display("first handler store issued outside the mtvec region");
            end
        end
        if (ctl[7:4] == 4'd3) begin
            irq = 1'b1;     // mtvec is written so raise the line
            epc = pc;       // word after this store is the first one that can be interrupted
        end
        rec_idx++;
        if (rec_idx == rec_cnt || pat[r + 4][11:8] != ctl[11:8]) report_test(ctl[11:8]);
    endtask

    // data memory model with done after 0 to 3 cycles
    task automatic serve_bus();
        int              o;
        int              nbytes;
        logic [XLEN-1:0] rd;
        if (done_q) begin
            if (bus_req.we || bus_req.re) begin
                errors++;
                $display("bus enable still high in the cycle after done");
            end
            bus_rsp.read_done  = 1'b0;
            bus_rsp.write_done = 1'b0;
            done_q             = 1'b0;
        end else if (bus_req.we || bus_req.re) begin
            if (!pending) begin
                pending = 1'b1;
                held    = bus_req;
                delay   = take_bits();
            end else begin
                check_bus(held, bus_req, "bus_req_o while waiting");
            end
            if (delay != 2'd0) begin
                delay = delay - 2'd1;
            end else begin
                o = int'(held.addr - 39'h2000);
                if (held.addr < 39'h2000 || o > 504) begin
                    errors++;
                    $display("access at %h outside the data memory", held.addr);
                    o = 0;
                end
                if (held.we) begin
                    match_store();
                    nbytes = 1 << held.ls_type[1:0];
                    for (int b = 0; b < nbytes; b++) dmem[o + b] = held.wdata[8*b +: 8];
                    bus_rsp.write_done = 1'b1;
                end else begin
                    for (int b = 0; b < 8; b++) rd[8*b +: 8] = dmem[o + b];  // right aligned
                    bus_rsp.rdata     = rd;
                    bus_rsp.read_done = 1'b1;
                end
                pending = 1'b0;
                done_q  = 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (irq_ack) begin
            ack_cnt++;
            irq = 1'b0;
        end
        if (pc >= RESET_PC && int'((pc - RESET_PC) >> 2) < 128) begin
            instruction = pat[int'((pc - RESET_PC) >> 2)][31:0];
        end else begin
            instruction = NOP_INSN;
        end
        serve_bus();
    end

    initial begin
        instruction = NOP_INSN;
        irq         = 1'b0;
        bus_rsp     = '0;
        pending     = 1'b0;
        done_q      = 1'b0;
        delay       = '0;
        epc         = '0;
        held        = '0;
        {rec_idx, ack_cnt, errors, err_mark, tests_run, tests_failed} = '0;
        timed_out   = 1'b0;
        for (int k = 0; k < 256; k++) pat[k] = '0;
        $readmemh("dv/rv_core_patterns.txt", pat);
        for (int k = 0; k < 512; k++) dmem[k] = 8'(k ^ (k >> 3));
        for (int i = 0; i < 8; i++) begin
            for (int b = 0; b < 8; b++) dmem['h100 + 8*i + b] = pat[DATA_AT + i][8*b +: 8];
        end
        rec_cnt    = int'(pat[INFO_AT][31:0]);
        handler_pc = pat[INFO_AT + 1][PC_W-1:0];

        cycles = 0;
        while (!timed_out) begin
            @(negedge clk);
            if (reset) break;
            cycles++;
            check_pc(RESET_PC, pc, "pc_o");
            check_bus('0, bus_req, "bus_req_o");
            if (irq_ack !== 1'b0) begin
                errors++;
                $display("irq_ack_o is not low during reset");
            end
            if (cycles > 20) begin
                timed_out = 1'b1;
                $display("timeout waiting for reset release");
            end
        end
        report_test(4'd1);

        cycles = 0;
        while (rec_idx < rec_cnt && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                timed_out = 1'b1;
                $display("timeout waiting for store record %0d", rec_idx);
            end
        end
        cycles = 0;
        while (cycles < 20 && !timed_out) begin   // catch stray stores
            @(negedge clk);
            cycles++;
        end
        if (ack_cnt != 1) begin
            errors++;
            $display("irq_ack_o pulsed %0d times instead of once", ack_cnt);
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* dv/rv_core_patterns.txt */
// program words from @00 and @48 (handler), data word at @80, @88 record count and handler pc
// records from @90: address, ctl (test, kind, ls_type), data; kind 1 is mepc, kind 3 raises irq
@00
000020B7 FF900113 06400193 00310233 0040B023 403102B3 0050B423 05514313
0060B823 03C15393 0070BC23 0191941B 0280B023 4044549B 0290B423 00312533
03C17593 00B56533 02A0B823 0021B633 00361633 02C0BC23 00318463 0E20BC23
00319463 0430B023 00314463 0E20BC23 00316463 00317463 0E20BC23 00315463
008006EF 0E20BC23 04D0B423 00000717 00C707E7 0E20BC23 04F0B823 10008803
1010C883 10209903 1060D983 1040AA03 1000EA83 1000BB03 0500BC23 0710B023
0720B423 0730B823 0740BC23 0950B023 0960B423 09608823 09609923 0960AA23
00000B97 040B8B93 305B9073 0800BC23 00000013 00000013 00000013 00000013
00000013 00000013 0A30B023 0A40B423 0000006F
@48
34101C73 341C1073 34201CF3 0B80B823 0B90BC23 30200073
@80
F1E2D3C4B5A69788
@88
1A 80000120
@90
2000 203 5D                 2008 203 FFFFFFFFFFFFFF95
2010 203 FFFFFFFFFFFFFFAC   2018 203 F
2020 203 FFFFFFFFC8000000   2028 203 FFFFFFFFFC800000
2030 203 39                 2038 203 1000000000
2040 303 64                 2048 303 80000084
2050 303 80000094           2058 403 FFFFFFFFFFFFFF88
2060 403 97                 2068 403 FFFFFFFFFFFFB5A6
2070 403 F1E2               2078 403 FFFFFFFFF1E2D3C4
2080 403 B5A69788           2088 403 F1E2D3C4B5A69788
2090 400 88                 2092 401 9788
2094 402 B5A69788           2098 533 0
20B0 513 0                  20B8 503 800000000000000B
20A0 503 64                 20A8 503 5D

/* filelist.f */
common/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
bus_unit/rv_bus_unit.sv
csr_unit/rv_csr_file.sv
hdl/rv_core_top.sv
dv/tb_clock_gen.sv
dv/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f filelist.f --top-module tb_rv_core \
        --Mdir obj_dir -o tb_rv_core; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
